/* bch_cfg.svh */
`ifndef BCH_CFG_SVH
`define BCH_CFG_SVH

// Field GF(2^4)
`define BCH_M 4

// Code length 2^m - 1
`define BCH_N 15

// Field generator x^4 + x + 1
`define BCH_PRIM_POLY 5'b1_0011

// Minimal polynomial of alpha, x^4 + x + 1
`define BCH_MIN_POLY1 5'b1_0011

// Minimal polynomial of alpha^3, x^4 + x^3 + x^2 + x + 1
`define BCH_MIN_POLY3 5'b1_1111

`endif

/* bch_pkg.sv */
`include "bch_cfg.svh"

package bch_pkg;

	// One element of GF(16) in the polynomial basis
	typedef logic [`BCH_M-1:0] gf_elem_t;

	// Remainder of r(x) mod f_j(x), bit i is the coefficient of x^i
	typedef logic [`BCH_M-1:0] rem_t;

	// Received word, bit 14 is the coefficient of x^14
	typedef logic [`BCH_N-1:0] codeword_t;

	// Handshake controller states
	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		HOLD
	} ctrl_state_t;

	// Product of two field elements reduced by the primitive polynomial.
	// Shift-and-add over the bits of b, a is multiplied by x each step.
	function automatic gf_elem_t gf_mult(gf_elem_t a, gf_elem_t b);
		logic [`BCH_M:0] prim;
		gf_elem_t acc;
		gf_elem_t x;
		logic carry;

		prim = `BCH_PRIM_POLY;
		acc = '0;
		x = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i]) begin
				acc = acc ^ x;
			end
			// Multiply by x and fold back the overflow term
			carry = x[`BCH_M-1];
			x = {x[`BCH_M-2:0], 1'b0};
			if (carry) begin
				x = x ^ prim[`BCH_M-1:0];
			end
		end
		return acc;
	endfunction

endpackage

/* syn_remainder.sv */
`timescale 1ns/10ps

`include "bch_cfg.svh"

// Bit-serial division of the received polynomial by one minimal
// polynomial. The word enters highest coefficient first, and after the
// last bit the register holds r(x) mod MIN_POLY(x).
module syn_remainder import bch_pkg::*; #(
	parameter logic [`BCH_M:0] MIN_POLY = `BCH_MIN_POLY1
) (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic ce,
	input  logic serial_bit,
	output rem_t rem
);

	// Leading term is implied, only the low taps feed back
	localparam rem_t TAPS = MIN_POLY[`BCH_M-1:0];

	logic feedback;
	rem_t shifted;
	rem_t rem_next;
	rem_t rem_first;

	// Multiply by x, bring in the next bit, reduce if degree reached m
	always_comb begin
		feedback = rem[`BCH_M-1];
		shifted = {rem[`BCH_M-2:0], serial_bit};
		if (feedback) begin
			rem_next = shifted ^ TAPS;
		end else begin
			rem_next = shifted;
		end
	end

	// First bit of a word replaces whatever the last word left behind
	assign rem_first = {{(`BCH_M-1){1'b0}}, serial_bit};

	always_ff @(posedge clk) begin
		if (rst) begin
			rem <= '0;
		end else if (start) begin
			rem <= rem_first;
		end else if (ce) begin
			rem <= rem_next;
		end
	end

endmodule

/* syn_expand.sv */
`timescale 1ns/10ps

`include "bch_cfg.svh"

// Evaluates b_j(alpha^POWER) for a remainder b_j of degree below m.
// Each coefficient selects a constant power of alpha, so the whole
// evaluation reduces to an XOR tree.
module syn_expand import bch_pkg::*; #(
	parameter int POWER = 1
) (
	input  rem_t     rem,
	output gf_elem_t syn
);

	// alpha is the root x of the primitive polynomial
	localparam gf_elem_t ALPHA = gf_elem_t'(2);

	// alpha^e computed by repeated multiplication at elaboration
	function automatic gf_elem_t alpha_pow(int e);
		gf_elem_t acc;
		int steps;

		acc = gf_elem_t'(1);
		steps = e % `BCH_N;
		for (int k = 0; k < steps; k++) begin
			acc = gf_mult(acc, ALPHA);
		end
		return acc;
	endfunction

	gf_elem_t term [`BCH_M];

	// Coefficient i contributes alpha^(POWER*i)
	for (genvar i = 0; i < `BCH_M; i++) begin : g_term
		localparam gf_elem_t APOW = alpha_pow(POWER * i);

		assign term[i] = rem[i] ? APOW : '0;
	end

	always_comb begin
		syn = '0;
		for (int i = 0; i < `BCH_M; i++) begin
			syn = syn ^ term[i];
		end
	end

endmodule

/* syn_ctrl.sv */
`timescale 1ns/10ps

`include "bch_cfg.svh"

// Four-phase req/ack controller. Latches the codeword, streams it
// highest bit first into the remainder units, then holds the result
// and the error flag until the source releases req.
module syn_ctrl import bch_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      req,
	input  codeword_t codeword,
	output logic      ack,
	output logic      start,
	output logic      ce,
	output logic      serial_bit,
	input  gf_elem_t  syn1,
	input  gf_elem_t  syn3,
	output logic      error_found
);

	// Counts 0..N, the extra count lets the last remainder settle
	localparam int CNT_W = $clog2(`BCH_N + 1);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`BCH_N);

	ctrl_state_t state;
	ctrl_state_t state_next;
	logic [CNT_W-1:0] bit_cnt;
	codeword_t shift_reg;
	logic accept;
	logic shift_done;
	logic syn_nonzero;

	assign accept = (state == IDLE) && req;
	assign shift_done = (bit_cnt == LAST_CNT);

	// Either odd syndrome nonzero means the word is not a codeword
	assign syn_nonzero = (syn1 != '0) || (syn3 != '0);

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (req) begin
					state_next = SHIFT;
				end
			end
			SHIFT: begin
				if (shift_done) begin
					state_next = HOLD;
				end
			end
			HOLD: begin
				// Release once the source has dropped req
				if (!req) begin
					state_next = IDLE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Bit position within the word while shifting
	always_ff @(posedge clk) begin
		if (rst) begin
			bit_cnt <= '0;
		end else if (state == SHIFT) begin
			bit_cnt <= bit_cnt + 1'b1;
		end else begin
			bit_cnt <= '0;
		end
	end

	// Codeword copy, MSB goes out first
	always_ff @(posedge clk) begin
		if (accept) begin
			shift_reg <= codeword;
		end else if (state == SHIFT) begin
			shift_reg <= {shift_reg[`BCH_N-2:0], 1'b0};
		end
	end

	assign serial_bit = shift_reg[`BCH_N-1];

	// First bit loads the dividers, the other 14 shift
	assign start = (state == SHIFT) && (bit_cnt == '0);
	assign ce = (state == SHIFT) && (bit_cnt != '0) && !shift_done;

	// Flag captured together with the move into HOLD
	always_ff @(posedge clk) begin
		if (rst) begin
			error_found <= 1'b0;
		end else if ((state == SHIFT) && shift_done) begin
			error_found <= syn_nonzero;
		end
	end

	// Syndromes are frozen for the whole of HOLD
	assign ack = (state == HOLD);

endmodule

/* bch_syndrome.sv */
`timescale 1ns/10ps

`include "bch_cfg.svh"

// BCH(15,7) odd syndrome calculator, S1 and S3 by remainder division
// followed by evaluation at alpha and alpha^3
module bch_syndrome import bch_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      req,
	input  codeword_t codeword,
	output logic      ack,
	output gf_elem_t  syn1,
	output gf_elem_t  syn3,
	output logic      error_found
);

	logic start;
	logic ce;
	logic serial_bit;
	rem_t rem1;
	rem_t rem3;

	syn_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.codeword    (codeword),
		.ack         (ack),
		.start       (start),
		.ce          (ce),
		.serial_bit  (serial_bit),
		.syn1        (syn1),
		.syn3        (syn3),
		.error_found (error_found)
	);

	// S1 path
	syn_remainder #(
		.MIN_POLY (`BCH_MIN_POLY1)
	) u_rem1 (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.ce         (ce),
		.serial_bit (serial_bit),
		.rem        (rem1)
	);

	syn_expand #(
		.POWER (1)
	) u_exp1 (
		.rem (rem1),
		.syn (syn1)
	);

	// S3 path
	syn_remainder #(
		.MIN_POLY (`BCH_MIN_POLY3)
	) u_rem3 (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.ce         (ce),
		.serial_bit (serial_bit),
		.rem        (rem3)
	);

	syn_expand #(
		.POWER (3)
	) u_exp3 (
		.rem (rem3),
		.syn (syn3)
	);

endmodule

/* bch_syndrome_assertions.sv */
`timescale 1ns/10ps

// Handshake and output stability checks for the syndrome calculator
module bch_syndrome_assertions import bch_pkg::*; (
	input logic     clk,
	input logic     rst,
	input logic     req,
	input logic     ack,
	input gf_elem_t syn1,
	input gf_elem_t syn3,
	input logic     error_found
);

	// Number of assertion failures so far
	int fail_count = 0;

	ack_low_in_reset: assert property (@(posedge clk) rst |=> !ack)
		else begin
			fail_count++;
			$error("ack high while reset is applied");
		end

	// HOLD is only entered while the source still requests
	ack_rise_with_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(req))
		else begin
			fail_count++;
			$error("ack rose while req was low");
		end

	outputs_stable: assert property (@(posedge clk) disable iff (rst)
		ack |=> (!ack || ($stable(syn1) && $stable(syn3) && $stable(error_found))))
		else begin
			fail_count++;
			$error("syndrome outputs changed while ack was high");
		end

	ack_fall_after_req: assert property (@(posedge clk) disable iff (rst)
		$fell(ack) |-> !$past(req))
		else begin
			fail_count++;
			$error("ack fell before req was sampled low");
		end

endmodule

bind bch_syndrome bch_syndrome_assertions u_assert (
	.clk         (clk),
	.rst         (rst),
	.req         (req),
	.ack         (ack),
	.syn1        (syn1),
	.syn3        (syn3),
	.error_found (error_found)
);

/* tb_bch_syndrome.sv */
`timescale 1ns/10ps

`include "bch_cfg.svh"

module tb_bch_syndrome import bch_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 40;
	// Generator x^8 + x^7 + x^6 + x^4 + 1
	localparam logic [8:0] GEN_POLY = 9'b1_1101_0001;

	logic clk;
	logic rst;
	logic req;
	codeword_t codeword;
	logic ack;
	gf_elem_t syn1;
	gf_elem_t syn3;
	logic error_found;

	int check_errors = 0;
	int timeout_errors = 0;
	codeword_t expected_q[$];
	logic ack_seen = 1'b0;
	gf_elem_t exp_syn1;
	gf_elem_t exp_syn3;
	logic exp_err;

	bch_syndrome DUT (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.codeword    (codeword),
		.ack         (ack),
		.syn1        (syn1),
		.syn3        (syn3),
		.error_found (error_found)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// S_j = r(alpha^j), Horner's rule from the x^14 coefficient down
	function automatic gf_elem_t ref_syndrome(codeword_t word, int j);
		gf_elem_t a;
		gf_elem_t acc;

		a = gf_elem_t'(1);
		for (int k = 0; k < j; k++) begin
			a = gf_mult(a, gf_elem_t'(2));
		end
		acc = '0;
		for (int i = `BCH_N - 1; i >= 0; i--) begin
			acc = gf_mult(acc, a) ^ gf_elem_t'(word[i]);
		end
		return acc;
	endfunction

	// Message polynomial times the generator, carry-less
	function automatic codeword_t encode_message(logic [6:0] msg);
		codeword_t cw;

		cw = '0;
		for (int i = 0; i < 7; i++) begin
			if (msg[i]) begin
				cw = cw ^ (codeword_t'(GEN_POLY) << i);
			end
		end
		return cw;
	endfunction

	task automatic check_gf(input string name, input gf_elem_t exp, input gf_elem_t act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
			check_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED at %0t: %s expected %b actual %b", $time, name, exp, act);
			check_errors++;
		end
	endtask

	// Results checked when ack first appears, then held against those values
	always @(negedge clk) begin : compare_results
		codeword_t word;

		if (rst || !ack) begin
			ack_seen = 1'b0;
		end else if (!ack_seen) begin
			ack_seen = 1'b1;
			if (expected_q.size() == 0) begin
				$display("ERROR at %0t: ack rose with no request outstanding", $time);
				check_errors++;
			end else begin
				word = expected_q.pop_front();
				exp_syn1 = ref_syndrome(word, 1);
				exp_syn3 = ref_syndrome(word, 3);
				exp_err = (exp_syn1 != '0) || (exp_syn3 != '0);
			end
		end
		if (ack_seen) begin
			check_gf("syn1", exp_syn1, syn1);
			check_gf("syn3", exp_syn3, syn3);
			check_bit("error_found", exp_err, error_found);
		end
	end

	// One four-phase transfer, req kept high extra_cycles after ack.
	// Entered 1 ns after a rising edge and left at the same phase
	task automatic send_word(input codeword_t word, input int extra_cycles);
		int waited;

		codeword = word;
		req = 1'b1;
		expected_q.push_back(word);
		waited = 0;
		while (ack !== 1'b1 && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (ack !== 1'b1) begin
			$display("ERROR at %0t: no ack within %0d cycles of req", $time, TIMEOUT_CYCLES);
			timeout_errors++;
			expected_q.delete();
		end
		repeat (extra_cycles) begin
			@(negedge clk);
			check_bit("ack", 1'b1, ack);
		end
		@(posedge clk);
		#1;
		req = 1'b0;
		waited = 0;
		while (ack !== 1'b0 && waited < TIMEOUT_CYCLES) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (ack !== 1'b0) begin
			$display("ERROR at %0t: ack still high %0d cycles after req fell", $time, TIMEOUT_CYCLES);
			timeout_errors++;
		end
	endtask

	initial begin
		codeword_t cw;
		int p1;
		int p2;
		int assert_errors;

		rst = 1'b1;
		req = 1'b0;
		codeword = '0;
		void'($urandom(32'h19a3_4288));
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_bit("ack", 1'b0, ack);
		// Cleared remainders evaluate to zero syndromes
		check_gf("syn1", '0, syn1);
		check_gf("syn3", '0, syn3);
		check_bit("error_found", 1'b0, error_found);
		@(posedge clk);
		#1;
		send_word('0, 0);

		// Codewords of the BCH code give all-zero syndromes
		for (int n = 0; n < 20; n++) begin
			cw = encode_message(7'($urandom));
			check_gf("reference syn1 of codeword", '0, ref_syndrome(cw, 1));
			check_gf("reference syn3 of codeword", '0, ref_syndrome(cw, 3));
			send_word(cw, 0);
		end

		// One flip on even passes, two distinct flips on odd ones
		for (int n = 0; n < 40; n++) begin
			cw = encode_message(7'($urandom));
			p1 = $urandom % 15;
			cw[p1] = ~cw[p1];
			if (n % 2 == 1) begin
				p2 = (p1 + 1 + $urandom % 14) % 15;
				cw[p2] = ~cw[p2];
			end
			check_bit("reference error flag", 1'b1,
				(ref_syndrome(cw, 1) != '0) || (ref_syndrome(cw, 3) != '0));
			send_word(cw, 0);
		end

		for (int n = 0; n < 200; n++) begin
			send_word(codeword_t'($urandom), 0);
		end

		// Back-pressure
		for (int n = 0; n < 20; n++) begin
			send_word(codeword_t'($urandom), $urandom % 11);
		end

		// Back-to-back, next req right after ack falls
		for (int n = 0; n < 20; n++) begin
			send_word(codeword_t'($urandom), 0);
		end

		@(negedge clk);
		if (expected_q.size() != 0) begin
			$display("ERROR at %0t: %0d requests never answered", $time, expected_q.size());
			check_errors++;
		end
		assert_errors = DUT.u_assert.fail_count;
		$display("Summary: %0d check errors, %0d timeouts, %0d assertion failures",
			check_errors, timeout_errors, assert_errors);
		if (check_errors + timeout_errors + assert_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+.
bch_pkg.sv
syn_remainder.sv
syn_expand.sv
syn_ctrl.sv
bch_syndrome.sv
bch_syndrome_assertions.sv
tb_bch_syndrome.sv
